//--- hdl/isa_pkg.sv
`default_nettype none

package isa_pkg;

	// Register code as it sits in the opcode fields
	// B, C, D, E, H, L, (HL), A
	typedef logic [2:0] reg_idx_t;

	localparam reg_idx_t REG_H      = 3'd4;
	localparam reg_idx_t REG_L      = 3'd5;
	// Code 6 is the indirect byte, not a register
	localparam reg_idx_t REG_HL_IND = 3'd6;
	localparam reg_idx_t REG_A      = 3'd7;

	// ALU group order matches opcode bits 5:3
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_ADC,
		ALU_SUB,
		ALU_SBC,
		ALU_AND,
		ALU_XOR,
		ALU_OR,
		ALU_CP,
		ALU_INC,
		ALU_DEC
	} alu_op_t;

	// Same bit order as F[7:4]
	typedef struct packed {
		logic z;
		logic n;
		logic h;
		logic c;
	} flags_t;

	// One register file update, issued in phase 3
	typedef struct packed {
		// 8-bit register write
		logic        we;
		reg_idx_t    dst;
		logic [7:0]  data;
		// Pair write, code 0 BC, 1 DE, 2 HL
		logic        pair_we;
		logic [1:0]  pair;
		logic [15:0] pair_data;
		// Flag write
		logic        flags_we;
		flags_t      flags;
		// Hold C as it was (INC/DEC)
		logic        keep_c;
	} reg_write_t;

endpackage

`default_nettype wire

//--- hdl/bus_pkg.sv
`default_nettype none

package bus_pkg;

	// Kind of the current machine cycle
	typedef enum logic [2:0] {
		OP_FETCH,
		IMML_FETCH,
		IMMH_FETCH,
		IND_FETCH,
		IND_STORE,
		JUMP
	} mstate_t;

	// Clock within a machine cycle, 0 to 3
	typedef logic [1:0] phase_t;

	// Memory side of the core
	typedef struct packed {
		logic [15:0] adr;
		logic [7:0]  dout;
		logic        ddrv;
		logic        read;
		logic        write;
	} mem_bus_t;

	// Request for the next machine cycle
	typedef struct packed {
		mstate_t     next;
		logic        adr_ld;
		logic [15:0] adr;
		logic        dout_ld;
		logic [7:0]  dout;
		logic        pc_ld;
		logic [15:0] pc_tgt;
	} access_t;

	// Bytes latched from din
	typedef struct packed {
		logic [7:0] op;
		logic [7:0] imml;
		logic [7:0] immh;
	} fetched_t;

endpackage

`default_nettype wire

//--- hdl/alu8.sv
`timescale 1ns/100ps
`default_nettype none

module alu8 (
	input  isa_pkg::alu_op_t op,
	input  logic [7:0]       a,
	input  logic [7:0]       b,
	input  logic             carry_in,
	output logic [7:0]       res,
	output isa_pkg::flags_t  flags
);

	// Carry into bit 0 for ADC and SBC only
	logic       cin;
	// Bit 8 and bit 4 are carry or borrow out
	logic [8:0] full;
	logic [4:0] low;

	assign cin = carry_in && ((op == isa_pkg::ALU_ADC) || (op == isa_pkg::ALU_SBC));

	always_comb
	begin
		full  = 9'd0;
		low   = 5'd0;
		res   = 8'd0;
		flags = '0;
		case (op)
		isa_pkg::ALU_ADD, isa_pkg::ALU_ADC:
		begin
			full = {1'b0, a} + {1'b0, b} + {8'd0, cin};
			low  = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, cin};
		end
		isa_pkg::ALU_SUB, isa_pkg::ALU_SBC, isa_pkg::ALU_CP:
		begin
			full    = {1'b0, a} - {1'b0, b} - {8'd0, cin};
			low     = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'd0, cin};
			flags.n = 1'b1;
		end
		isa_pkg::ALU_AND:
		begin
			full    = {1'b0, a & b};
			flags.h = 1'b1;
		end
		isa_pkg::ALU_XOR: full = {1'b0, a ^ b};
		isa_pkg::ALU_OR:  full = {1'b0, a | b};
		isa_pkg::ALU_INC:
		begin
			full = {1'b0, b} + 9'd1;
			low  = {1'b0, b[3:0]} + 5'd1;
		end
		isa_pkg::ALU_DEC:
		begin
			full    = {1'b0, b} - 9'd1;
			low     = {1'b0, b[3:0]} - 5'd1;
			flags.n = 1'b1;
		end
		default:
			;
		endcase
		res = full[7:0];
		// Logic ops leave low at zero, AND forces H above
		if ((op != isa_pkg::ALU_AND) && (op != isa_pkg::ALU_XOR) && (op != isa_pkg::ALU_OR))
			flags.h = low[4];
		flags.c = full[8];
		flags.z = res == 8'd0;
	end

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
	input  logic                clk,
	input  logic                reset,
	input  isa_pkg::reg_idx_t   src_sel,
	input  isa_pkg::reg_idx_t   dst_sel_inc,
	input  logic [7:0]          imml,
	input  isa_pkg::reg_write_t wr,
	output logic [7:0]          a,
	output logic [7:0]          src,
	output logic [7:0]          inc_src,
	output logic [15:0]         hl,
	output isa_pkg::flags_t     f
);

	// Indexed by register code, slot 6 stays unused
	logic [7:0] rf [0:7];

	assign a  = rf[isa_pkg::REG_A];
	assign hl = {rf[isa_pkg::REG_H], rf[isa_pkg::REG_L]};

	// Code 6 reads the latched (HL) or immediate byte
	assign src     = (src_sel == isa_pkg::REG_HL_IND) ? imml : rf[src_sel];
	assign inc_src = (dst_sel_inc == isa_pkg::REG_HL_IND) ? imml : rf[dst_sel_inc];

	always_ff @(posedge clk)
	begin
		if (wr.we && (wr.dst != isa_pkg::REG_HL_IND))
			rf[wr.dst] <= wr.data;
		// Pair code doubles as the high register index
		if (wr.pair_we)
		begin
			rf[{wr.pair, 1'b0}] <= wr.pair_data[15:8];
			rf[{wr.pair, 1'b1}] <= wr.pair_data[7:0];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			f <= '0;
		else if (wr.flags_we)
		begin
			f.z <= wr.flags.z;
			f.n <= wr.flags.n;
			f.h <= wr.flags.h;
			f.c <= wr.keep_c ? f.c : wr.flags.c;
		end
	end

	// Decoder never issues both write kinds in one cycle
	assert property (@(posedge clk) disable iff (reset) !(wr.we && wr.pair_we));

endmodule

`default_nettype wire

//--- hdl/instr_control.sv
`timescale 1ns/100ps
`default_nettype none

module instr_control (
	input  bus_pkg::mstate_t    mstate,
	input  bus_pkg::phase_t     phase,
	input  bus_pkg::fetched_t   fetched,
	input  logic [15:0]         pc,
	input  logic [15:0]         hl,
	input  logic [7:0]          src,
	input  isa_pkg::flags_t     acc_flags,
	input  logic [7:0]          alu_res,
	input  isa_pkg::flags_t     alu_flags,
	output isa_pkg::reg_idx_t   src_sel,
	output isa_pkg::alu_op_t    alu_op,
	output bus_pkg::access_t    access,
	output isa_pkg::reg_write_t wr
);

	// Instruction groups
	typedef enum logic [2:0] {
		CL_NOP,
		CL_LD_RR,
		CL_LD_D8,
		CL_LD_D16,
		CL_ALU,
		CL_ALU_D8,
		CL_INCDEC,
		CL_JP
	} op_class_t;

	op_class_t         op_class;
	logic [7:0]        op;
	isa_pkg::reg_idx_t dst;
	isa_pkg::reg_idx_t srcf;
	logic              taken;

	assign op   = fetched.op;
	assign dst  = op[5:3];
	assign srcf = op[2:0];

	// Z or C against opcode bit 3, unconditional when bit 0 set
	assign taken = op[0] || ((op[4] ? acc_flags.c : acc_flags.z) == op[3]);

	always_comb
	begin
		casez (op)
		8'h76:                      op_class = CL_NOP;
		8'b01??????:                op_class = CL_LD_RR;
		8'b00???110:                op_class = CL_LD_D8;
		8'h01, 8'h11, 8'h21:        op_class = CL_LD_D16;
		8'b10??????:                op_class = CL_ALU;
		8'b11???110:                op_class = CL_ALU_D8;
		8'b00???10?:                op_class = CL_INCDEC;
		8'hc3, 8'hc2, 8'hca,
		8'hd2, 8'hda:               op_class = CL_JP;
		default:                    op_class = CL_NOP;
		endcase
	end

	// INC/DEC work on bits 5:3, the group on bits 2:0
	assign src_sel = (op_class == CL_INCDEC) ? dst : srcf;
	assign alu_op  = (op_class == CL_INCDEC) ?
		(op[0] ? isa_pkg::ALU_DEC : isa_pkg::ALU_INC) :
		isa_pkg::alu_op_t'({1'b0, op[5:3]});

	always_comb
	begin
		// Back to opcode fetch unless a case says otherwise
		access.next    = bus_pkg::OP_FETCH;
		access.adr_ld  = 1'b0;
		access.adr     = pc;
		access.dout_ld = 1'b0;
		access.dout    = src;
		access.pc_ld   = 1'b0;
		access.pc_tgt  = {fetched.immh, fetched.imml};

		wr.we        = 1'b0;
		wr.dst       = dst;
		wr.data      = src;
		wr.pair_we   = 1'b0;
		wr.pair      = op[5:4];
		wr.pair_data = {fetched.immh, fetched.imml};
		wr.flags_we  = 1'b0;
		wr.flags     = alu_flags;
		wr.keep_c    = 1'b0;

		case (op_class)
		CL_LD_RR:
			if (srcf == isa_pkg::REG_HL_IND)
			begin
				// LD r,(HL) reads first, then writes r
				if (mstate == bus_pkg::OP_FETCH)
				begin
					access.next   = bus_pkg::IND_FETCH;
					access.adr    = hl;
					access.adr_ld = 1'b1;
				end
				else
					wr.we = 1'b1;
			end
			else if (dst == isa_pkg::REG_HL_IND)
			begin
				if (mstate == bus_pkg::OP_FETCH)
				begin
					access.next    = bus_pkg::IND_STORE;
					access.adr     = hl;
					access.adr_ld  = 1'b1;
					access.dout_ld = 1'b1;
				end
			end
			else
				wr.we = 1'b1;
		CL_LD_D8:
			if (mstate == bus_pkg::OP_FETCH)
				access.next = bus_pkg::IMML_FETCH;
			else if (mstate == bus_pkg::IMML_FETCH)
			begin
				// src is the immediate here
				if (dst == isa_pkg::REG_HL_IND)
				begin
					access.next    = bus_pkg::IND_STORE;
					access.adr     = hl;
					access.adr_ld  = 1'b1;
					access.dout_ld = 1'b1;
				end
				else
					wr.we = 1'b1;
			end
		CL_LD_D16:
			if (mstate == bus_pkg::OP_FETCH)
				access.next = bus_pkg::IMML_FETCH;
			else if (mstate == bus_pkg::IMML_FETCH)
				access.next = bus_pkg::IMMH_FETCH;
			else
				wr.pair_we = 1'b1;
		CL_ALU, CL_ALU_D8:
			if ((mstate == bus_pkg::OP_FETCH) && (srcf == isa_pkg::REG_HL_IND))
			begin
				if (op_class == CL_ALU_D8)
					access.next = bus_pkg::IMML_FETCH;
				else
				begin
					access.next   = bus_pkg::IND_FETCH;
					access.adr    = hl;
					access.adr_ld = 1'b1;
				end
			end
			else
			begin
				// CP only updates flags
				wr.dst      = isa_pkg::REG_A;
				wr.data     = alu_res;
				wr.we       = alu_op != isa_pkg::ALU_CP;
				wr.flags_we = 1'b1;
			end
		CL_INCDEC:
		begin
			wr.data   = alu_res;
			wr.keep_c = 1'b1;
			if (dst == isa_pkg::REG_HL_IND)
			begin
				// Read, modify, write back to the same address
				if (mstate == bus_pkg::OP_FETCH)
				begin
					access.next   = bus_pkg::IND_FETCH;
					access.adr    = hl;
					access.adr_ld = 1'b1;
				end
				else if (mstate == bus_pkg::IND_FETCH)
				begin
					access.next    = bus_pkg::IND_STORE;
					access.dout    = alu_res;
					access.dout_ld = 1'b1;
					wr.flags_we    = 1'b1;
				end
			end
			else
			begin
				wr.we       = 1'b1;
				wr.flags_we = 1'b1;
			end
		end
		CL_JP:
			case (mstate)
			bus_pkg::OP_FETCH:   access.next = bus_pkg::IMML_FETCH;
			bus_pkg::IMML_FETCH: access.next = bus_pkg::IMMH_FETCH;
			// Extra cycle only when taken
			bus_pkg::IMMH_FETCH: access.next = taken ? bus_pkg::JUMP : bus_pkg::OP_FETCH;
			default:             access.pc_ld = 1'b1;
			endcase
		default:
			;
		endcase

		// Writes land only on the phase 3 edge
		if (phase != 2'd3)
		begin
			wr.we       = 1'b0;
			wr.pair_we  = 1'b0;
			wr.flags_we = 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- hdl/bus_cycle_seq.sv
`timescale 1ns/100ps
`default_nettype none

module bus_cycle_seq #(
	parameter logic [15:0] RESET_PC = 16'h0000
) (
	input  logic              clk,
	input  logic              reset,
	input  logic [7:0]        din,
	input  bus_pkg::access_t  access,
	output bus_pkg::mem_bus_t bus,
	output logic [15:0]       pc,
	output bus_pkg::mstate_t  mstate,
	output bus_pkg::phase_t   phase,
	output bus_pkg::fetched_t fetched
);

	logic [15:0] adr_q;
	logic [7:0]  dout_q;
	logic        ddrv_q;
	logic        read_q;
	logic        write_q;

	// Cycle kinds
	logic        pc_fetch;
	logic        rd_cycle;
	logic        wr_cycle;

	// Opcode and immediates come from PC
	assign pc_fetch = (mstate == bus_pkg::OP_FETCH) || (mstate == bus_pkg::IMML_FETCH) ||
		(mstate == bus_pkg::IMMH_FETCH);
	assign rd_cycle = pc_fetch || (mstate == bus_pkg::IND_FETCH);
	assign wr_cycle = mstate == bus_pkg::IND_STORE;

	assign bus = '{adr: adr_q, dout: dout_q, ddrv: ddrv_q, read: read_q, write: write_q};

	// Phase counter, state, PC and strobes
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			phase   <= 2'd0;
			mstate  <= bus_pkg::OP_FETCH;
			pc      <= RESET_PC;
			ddrv_q  <= 1'b0;
			read_q  <= 1'b0;
			write_q <= 1'b0;
		end
		else
		begin
			phase <= phase + 2'd1;
			case (phase)
			2'd0:
			begin
				// Release data for reads, drive it ahead of a write
				if (rd_cycle)
					ddrv_q <= 1'b0;
				else if (wr_cycle)
					ddrv_q <= 1'b1;
			end
			2'd1:
			begin
				if (rd_cycle)
					read_q <= 1'b1;
				if (wr_cycle)
					write_q <= 1'b1;
				if (pc_fetch)
					pc <= pc + 16'd1;
			end
			2'd2:
				write_q <= 1'b0;
			2'd3:
			begin
				read_q <= 1'b0;
				mstate <= access.next;
				// Taken jump
				if (access.pc_ld)
					pc <= access.pc_tgt;
			end
			endcase
		end
	end

	// Address, store byte and fetched bytes
	always_ff @(posedge clk)
	begin
		case (phase)
		2'd0:
			if (pc_fetch)
				adr_q <= pc;
		2'd2:
			if (rd_cycle)
			begin
				case (mstate)
				bus_pkg::OP_FETCH:   fetched.op   <= din;
				bus_pkg::IMMH_FETCH: fetched.immh <= din;
				// Immediate low byte or the (HL) byte
				default:             fetched.imml <= din;
				endcase
			end
		2'd3:
		begin
			if (access.adr_ld)
				adr_q <= access.adr;
			if (access.dout_ld)
				dout_q <= access.dout;
		end
		default:
			;
		endcase
	end

	// Strobes are exclusive
	assert property (@(posedge clk) disable iff (reset) !(bus.read && bus.write));

	// Store data is on the bus for the whole write pulse
	assert property (@(posedge clk) disable iff (reset) bus.write |-> bus.ddrv);

endmodule

`default_nettype wire

//--- hdl/cpu_core.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_core #(
	parameter logic [15:0] RESET_PC = 16'h0000
) (
	input  logic              clk,
	input  logic              reset,
	input  logic [7:0]        din,
	output bus_pkg::mem_bus_t bus,
	output logic [15:0]       pc,
	output isa_pkg::flags_t   f
);

	bus_pkg::access_t    access;
	bus_pkg::mstate_t    mstate;
	bus_pkg::phase_t     phase;
	bus_pkg::fetched_t   fetched;
	isa_pkg::reg_write_t wr;
	isa_pkg::alu_op_t    alu_op;
	// Register code of the ALU operand
	isa_pkg::reg_idx_t   alu_sel;
	isa_pkg::flags_t     alu_flags;
	logic [7:0]          a;
	logic [7:0]          src;
	logic [7:0]          alu_b;
	logic [7:0]          alu_res;
	logic [15:0]         hl;

	bus_cycle_seq #(
		.RESET_PC(RESET_PC)
	) i_bus_cycle_seq (
		.clk    (clk),
		.reset  (reset),
		.din    (din),
		.access (access),
		.bus    (bus),
		.pc     (pc),
		.mstate (mstate),
		.phase  (phase),
		.fetched(fetched)
	);

	instr_control i_instr_control (
		.mstate   (mstate),
		.phase    (phase),
		.fetched  (fetched),
		.pc       (pc),
		.hl       (hl),
		.src      (src),
		.acc_flags(f),
		.alu_res  (alu_res),
		.alu_flags(alu_flags),
		.src_sel  (alu_sel),
		.alu_op   (alu_op),
		.access   (access),
		.wr       (wr)
	);

	// Load source is always opcode bits 2:0
	reg_file i_reg_file (
		.clk        (clk),
		.reset      (reset),
		.src_sel    (fetched.op[2:0]),
		.dst_sel_inc(alu_sel),
		.imml       (fetched.imml),
		.wr         (wr),
		.a          (a),
		.src        (src),
		.inc_src    (alu_b),
		.hl         (hl),
		.f          (f)
	);

	alu8 i_alu8 (
		.op      (alu_op),
		.a       (a),
		.b       (alu_b),
		.carry_in(f.c),
		.res     (alu_res),
		.flags   (alu_flags)
	);

endmodule

`default_nettype wire

//--- sim/tb_programs.svh
// Idle bus in reset, then first read at the vector
task automatic reset_state_test();
	logic [15:0] got;
	start_prog();
	park_here();
	repeat (2) @(posedge clk);
	// Packed as ddrv, read, write
	check_byte("ddrv/read/write", {5'd0, bus.ddrv, bus.read, bus.write}, 8'h00);
	check_addr("pc", pc, START);
	@(posedge clk);
	reset <= 1'b0;
	wait_fetch_in(16'h0000, 16'hffff, got);
	check_addr("first read adr", got, START);
endtask

task automatic load_test();
	logic [7:0] v [0:6];
	int         k;
	for (k = 0; k < 7; k++)
		v[k] = lcg_byte();
	start_prog();
	emit_d16(8'h21, 16'h8000);
	// LD B, C, D, E, A with d8
	emit_d8(8'h06, v[0]);
	emit_d8(8'h0e, v[1]);
	emit_d8(8'h16, v[2]);
	emit_d8(8'h1e, v[3]);
	emit_d8(8'h3e, v[4]);
	// Each store moves L first
	emit_d8(8'h2e, 8'h00);
	emit(8'h70);
	emit_d8(8'h2e, 8'h01);
	emit(8'h71);
	emit_d8(8'h2e, 8'h02);
	emit(8'h72);
	emit_d8(8'h2e, 8'h03);
	emit(8'h73);
	emit_d8(8'h2e, 8'h04);
	emit(8'h77);
	// LD (HL),d8
	emit_d8(8'h2e, 8'h05);
	emit_d8(8'h36, v[5]);
	// Chain B=A, C=E, D=C, E=B, A=D
	emit(8'h47);
	emit(8'h4b);
	emit(8'h51);
	emit(8'h58);
	emit(8'h7a);
	emit_d8(8'h2e, 8'h10);
	emit(8'h70);
	emit_d8(8'h2e, 8'h11);
	emit(8'h71);
	emit_d8(8'h2e, 8'h12);
	emit(8'h72);
	emit_d8(8'h2e, 8'h13);
	emit(8'h73);
	emit_d8(8'h2e, 8'h14);
	emit(8'h77);
	// A taken from H and then from L, each stored
	emit(8'h7c);
	emit_d8(8'h2e, 8'h15);
	emit(8'h77);
	emit(8'h7d);
	emit_d8(8'h2e, 8'h16);
	emit(8'h77);
	// LD H,d8, then H and L stored through (HL)
	emit_d8(8'h26, 8'h81);
	emit_d8(8'h2e, 8'h20);
	emit(8'h74);
	emit_d8(8'h2e, 8'h21);
	emit(8'h75);
	// LD C,(HL) copies the preloaded byte
	emit_d16(8'h21, 16'h8200);
	emit(8'h4e);
	emit_d16(8'h21, 16'h8201);
	emit(8'h71);
	park_here();
	mem[16'h8200] = v[6];
	run_to_park();
	for (k = 0; k < 6; k++)
		check_mem(16'h8000 + k[15:0], v[k]);
	check_mem(16'h8010, v[4]);
	check_mem(16'h8011, v[3]);
	check_mem(16'h8012, v[3]);
	check_mem(16'h8013, v[4]);
	check_mem(16'h8014, v[3]);
	check_mem(16'h8015, 8'h80);
	check_mem(16'h8016, 8'h15);
	check_mem(16'h8120, 8'h81);
	check_mem(16'h8121, 8'h21);
	check_mem(16'h8201, v[6]);
endtask

// form 0 register, 1 immediate, 2 (HL)
task automatic alu_case(input logic [2:0] k, input int form);
	logic [7:0]      a;
	logic [7:0]      b;
	logic            cin;
	logic [2:0]      r;
	logic [7:0]      res;
	isa_pkg::flags_t fl;
	a = lcg_byte();
	b = lcg_byte();
	cin = lcg_byte() > 8'h7f;
	// One of B, C, D, E
	r = {1'b0, k[1:0]};
	start_prog();
	// FF+FF sets C, FF+00 clears it
	emit_d8(8'h3e, 8'hff);
	emit_d8(8'hc6, cin ? 8'hff : 8'h00);
	emit_d8(8'h3e, a);
	case (form)
	0:
	begin
		emit_d8({2'b00, r, 3'b110}, b);
		emit({2'b10, k, r});
	end
	1:
		emit_d8({2'b11, k, 3'b110}, b);
	default:
	begin
		emit_d16(8'h21, 16'h8100);
		mem[16'h8100] = b;
		emit({2'b10, k, 3'b110});
	end
	endcase
	emit_d16(8'h21, 16'h8000);
	emit(8'h77);
	park_here();
	run_to_park();
	alu_model(k, a, b, cin, res, fl);
	// CP keeps A
	check_mem(16'h8000, (k == 3'd7) ? a : res);
	check_flags("f", f, fl);
endtask

task automatic alu_test();
	int k;
	int form;
	for (k = 0; k < 8; k++)
		for (form = 0; form < 3; form++)
			alu_case(k[2:0], form);
endtask

task automatic inc_dec_case(input logic is_dec, input logic ind, input logic carry,
		input logic [7:0] val);
	logic [2:0]      r;
	logic [7:0]      res;
	isa_pkg::flags_t fl;
	r = {1'b0, is_dec, carry};
	start_prog();
	emit_d8(8'h3e, 8'hff);
	emit_d8(8'hc6, carry ? 8'hff : 8'h00);
	if (ind)
	begin
		emit_d16(8'h21, 16'h8000);
		emit_d8(8'h36, val);
		// INC (HL) 34, DEC (HL) 35
		emit({7'b0011010, is_dec});
	end
	else
	begin
		emit_d8({2'b00, r, 3'b110}, val);
		emit({2'b00, r, 2'b10, is_dec});
		emit_d16(8'h21, 16'h8000);
		emit({5'b01110, r});
	end
	park_here();
	run_to_park();
	res = is_dec ? val - 8'd1 : val + 8'd1;
	fl.z = res == 8'h00;
	fl.n = is_dec;
	// Borrow into or carry out of the low nibble
	fl.h = is_dec ? (val[3:0] == 4'h0) : (val[3:0] == 4'hf);
	fl.c = carry;
	check_mem(16'h8000, res);
	check_flags("f", f, fl);
endtask

// Wrap operands first, LCG operands after
task automatic inc_dec_test();
	int m;
	for (m = 0; m < 16; m++)
		inc_dec_case(m[0], m[1], m[2], m[3] ? lcg_byte() : (m[0] ? 8'h00 : 8'hff));
endtask

task automatic jump_case(input logic [7:0] opc, input logic [7:0] x, input logic [7:0] y);
	logic [15:0]     tgt;
	logic [15:0]     fall;
	logic [15:0]     got;
	logic [7:0]      res;
	isa_pkg::flags_t fl;
	logic            taken;
	tgt = START + 16'h0040;
	// Byte after LD A, CP and JP
	fall = START + 16'd7;
	start_prog();
	emit_d8(8'h3e, x);
	emit_d8(8'hfe, y);
	emit_d16(opc, tgt);
	park_here();
	wp = tgt;
	park_here();
	alu_model(3'd7, x, y, 1'b0, res, fl);
	case (opc)
	8'hc2: taken = !fl.z;
	8'hca: taken = fl.z;
	8'hd2: taken = !fl.c;
	8'hda: taken = fl.c;
	default: taken = 1'b1;
	endcase
	release_reset();
	wait_fetch_in(fall, tgt, got);
	check_addr("next opcode fetch", got, taken ? tgt : fall);
	check_flags("f", f, fl);
endtask

// CP pairs give NZ NC, Z NC, NZ C
task automatic jump_test();
	logic [7:0] ops [0:4];
	int         i;
	ops = '{8'hc3, 8'hc2, 8'hca, 8'hd2, 8'hda};
	for (i = 0; i < 5; i++)
	begin
		jump_case(ops[i], 8'h50, 8'h30);
		jump_case(ops[i], 8'h44, 8'h44);
		jump_case(ops[i], 8'h30, 8'h50);
	end
endtask

//--- sim/tb_cpu_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_core;

	// Programs start at the reset vector
	localparam logic [15:0] START = 16'h0100;
	// Instructions over all test programs, rounded up
	localparam int INSTR_TOTAL = 420;
	// Program runs, each with its reset time
	localparam int RUNS = 60;
	// Up to 4 machine cycles of 400 ns per instruction
	localparam int WATCHDOG_NS = INSTR_TOTAL * 4 * 400 + RUNS * 8 * 100 + 50000;
	localparam int WAIT_CYCLES = 1000;

	logic              clk = 1'b0;
	logic              reset = 1'b1;
	logic [7:0]        din = 8'h00;
	bus_pkg::mem_bus_t bus;
	logic [15:0]       pc;
	isa_pkg::flags_t   f;

	logic [7:0]  mem [0:65535];
	logic [31:0] rng_state = 32'h381a;
	// Program write pointer
	logic [15:0] wp;
	// Address of the parking jump
	logic [15:0] end_addr;
	int          errors = 0;

	cpu_core #(
		.RESET_PC(START)
	) i_cpu_core (
		.clk  (clk),
		.reset(reset),
		.din  (din),
		.bus  (bus),
		.pc   (pc),
		.f    (f)
	);

	always #50 clk = ~clk;

	// Memory model, read data valid one clock after adr
	always @(posedge clk)
	begin
		if (bus.write)
			mem[bus.adr] = bus.dout;
		din <= mem[bus.adr];
	end

	task automatic stop_run();
		errors++;
		$display("Test failures found");
		$fatal(1);
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the core stopped making progress", WATCHDOG_NS);
		stop_run();
	end

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
		begin
			$display("FAIL %0t ns: %s is %02h, expected %02h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_addr(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp)
		begin
			$display("FAIL %0t ns: %s is %04h, expected %04h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_flags(input string name, input isa_pkg::flags_t got,
			input isa_pkg::flags_t exp);
		if (got !== exp)
		begin
			$display("FAIL %0t ns: %s is %b, expected %b (znhc)", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_mem(input logic [15:0] addr, input logic [7:0] exp);
		check_byte($sformatf("mem[%04h]", addr), mem[addr], exp);
	endtask

	function automatic logic [7:0] lcg_byte();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		// Upper bits have the longer period
		return rng_state[23:16];
	endfunction

	// Expected ALU result, op in opcode order ADD..CP
	task automatic alu_model(input logic [2:0] op, input logic [7:0] a, input logic [7:0] b,
			input logic cin, output logic [7:0] res, output isa_pkg::flags_t fl);
		int c;
		int full;
		int low;
		// Carry in for ADC and SBC only
		c = ((op == 3'd1) || (op == 3'd3)) ? cin : 0;
		fl = '0;
		case (op)
		3'd0, 3'd1:
		begin
			full = a + b + c;
			low = a[3:0] + b[3:0] + c;
			fl.h = low > 15;
			fl.c = full > 255;
		end
		3'd4:
		begin
			full = a & b;
			fl.h = 1'b1;
		end
		3'd5:
			full = a ^ b;
		3'd6:
			full = a | b;
		default:
		begin
			// SUB, SBC, CP; negative means borrow
			full = a - b - c;
			low = a[3:0] - b[3:0] - c;
			fl.n = 1'b1;
			fl.h = low < 0;
			fl.c = full < 0;
		end
		endcase
		res = full[7:0];
		fl.z = res == 8'h00;
	endtask

	task automatic emit(input logic [7:0] b);
		mem[wp] = b;
		wp = wp + 16'd1;
	endtask

	task automatic emit_d8(input logic [7:0] op, input logic [7:0] d);
		emit(op);
		emit(d);
	endtask

	// Immediate goes low byte first
	task automatic emit_d16(input logic [7:0] op, input logic [15:0] d);
		emit(op);
		emit(d[7:0]);
		emit(d[15:8]);
	endtask

	// JP to itself parks the core
	task automatic park_here();
		end_addr = wp;
		emit_d16(8'hc3, end_addr);
	endtask

	// Reset on, then refill memory
	task automatic start_prog();
		int i;
		@(posedge clk);
		reset <= 1'b1;
		@(posedge clk);
		for (i = 0; i < 65536; i++)
			mem[i] = i[15:8] ^ i[7:0] ^ 8'h5a;
		wp = START;
	endtask

	// Five reset edges in all with start_prog
	task automatic release_reset();
		repeat (4) @(posedge clk);
		reset <= 1'b0;
	endtask

	// First read strobe with adr inside lo..hi
	task automatic wait_fetch_in(input logic [15:0] lo, input logic [15:0] hi,
			output logic [15:0] got);
		int n;
		got = 16'h0000;
		for (n = 0; n < WAIT_CYCLES; n++)
		begin
			@(posedge clk);
			if (bus.read && (bus.adr >= lo) && (bus.adr <= hi))
			begin
				got = bus.adr;
				return;
			end
		end
		$display("Timed out waiting for a read between %04h and %04h", lo, hi);
		stop_run();
	endtask

	task automatic run_to_park();
		logic [15:0] got;
		release_reset();
		wait_fetch_in(end_addr, end_addr, got);
	endtask

	`include "tb_programs.svh"

	initial
	begin
		reset_state_test();
		load_test();
		alu_test();
		inc_dec_test();
		jump_test();
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+sim
hdl/isa_pkg.sv
hdl/bus_pkg.sv
hdl/alu8.sv
hdl/reg_file.sv
hdl/instr_control.sv
hdl/bus_cycle_seq.sv
hdl/cpu_core.sv
sim/tb_cpu_core.sv
